/* flist.f */
+incdir+tests
rtl/book_pkg.sv
rtl/level_list_exe.sv
rtl/state_table.sv
rtl/upd_decode.sv
rtl/upd_execute.sv
rtl/upd_result.sv
rtl/book_update_top.sv
tests/tb_book_update.sv

/* rtl/book_pkg.sv */
/*
 * Book updater shared definitions
 * Widths, update commands, request, level-list state and notify types
 * used across the four-stage update pipeline
 */

package book_pkg;

  // Product id, price key and volume widths
  localparam int ID_W      = 3;
  localparam int KEY_W     = 16;
  localparam int VOL_W     = 16;

  // Levels held per product
  localparam int ENTRIES_N = 4;

  typedef logic [ID_W-1:0]  id_t;
  typedef logic [KEY_W-1:0] key_t;
  typedef logic [VOL_W-1:0] vol_t;

  // Update commands
  typedef enum logic [1:0] {
    CMD_ADD = 2'd0,
    CMD_DEL = 2'd1,
    CMD_CLR = 2'd2
  } cmd_t;

  // Update request, 37 bits
  typedef struct packed {
    id_t  id;
    cmd_t cmd;
    key_t key;
    vol_t size;
  } upd_req_t;

  // Per-product level list, 132 bits
  // Entry 0 is the best (highest) key
  // Valid entries are contiguous from index 0
  typedef struct packed {
    logic [ENTRIES_N-1:0] vld;
    key_t [ENTRIES_N-1:0] key;
    vol_t [ENTRIES_N-1:0] vol;
  } book_state_t;

  // New best level, 35 bits
  // Key 0 with volume 0 marks an empty list
  typedef struct packed {
    id_t  id;
    key_t key;
    vol_t vol;
  } notify_t;

endpackage

/* rtl/book_update_top.sv */
/*
 * Price-level book updater top level
 * Four-stage pipeline: decode (S1/S2), execute (S3), result (S4)
 * around an internal per-product state table
 */

`timescale 1ns/1ps

module book_update_top #(
  parameter int PRODUCTS_N = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_upd_vld,
  input  book_pkg::upd_req_t i_upd,
  output logic               o_notify_vld,
  output book_pkg::notify_t  o_notify
);
  import book_pkg::*;

  // State table read port
  logic        rd_en;
  id_t         rd_addr;
  book_state_t rd_data;
  logic        st_ready;

  // Decode to execute
  logic        s2_vld;
  upd_req_t    s2_req;
  logic        s2_wrbk_vld;
  book_state_t s2_wrbk_state;

  // Execute to result
  logic        s3_vld;
  id_t         s3_id;
  book_state_t nxt_state;
  logic        exe_notify_vld;
  notify_t     exe_notify;

  // Stage-4 writeback, shared by table, decode and execute
  logic        wb_vld;
  id_t         wb_id;
  book_state_t wb_state;

  upd_decode i_upd_decode (
    .clk             (clk),
    .rst             (rst),
    .i_upd_vld       (i_upd_vld),
    .i_upd           (i_upd),
    .i_wb_vld        (wb_vld),
    .i_wb_id         (wb_id),
    .i_wb_state      (wb_state),
    .o_rd_en         (rd_en),
    .o_rd_addr       (rd_addr),
    .o_s2_vld        (s2_vld),
    .o_s2_req        (s2_req),
    .o_s2_wrbk_vld   (s2_wrbk_vld),
    .o_s2_wrbk_state (s2_wrbk_state)
  );

  state_table #(
    .PRODUCTS_N (PRODUCTS_N)
  ) i_state_table (
    .clk       (clk),
    .rst       (rst),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .i_wr_en   (wb_vld),
    .i_wr_addr (wb_id),
    .i_wr_data (wb_state),
    .o_rd_data (rd_data),
    .o_ready   (st_ready)
  );

  upd_execute i_upd_execute (
    .clk             (clk),
    .rst             (rst),
    .i_s2_vld        (s2_vld),
    .i_s2_req        (s2_req),
    .i_s2_wrbk_vld   (s2_wrbk_vld),
    .i_s2_wrbk_state (s2_wrbk_state),
    .i_rd_data       (rd_data),
    .i_wb_vld        (wb_vld),
    .i_wb_id         (wb_id),
    .i_wb_state      (wb_state),
    .o_s3_vld        (s3_vld),
    .o_s3_id         (s3_id),
    .o_nxt_state     (nxt_state),
    .o_notify_vld    (exe_notify_vld),
    .o_notify        (exe_notify)
  );

  upd_result i_upd_result (
    .clk          (clk),
    .rst          (rst),
    .i_s3_vld     (s3_vld),
    .i_s3_id      (s3_id),
    .i_nxt_state  (nxt_state),
    .i_notify_vld (exe_notify_vld),
    .i_notify     (exe_notify),
    .o_wb_vld     (wb_vld),
    .o_wb_id      (wb_id),
    .o_wb_state   (wb_state),
    .o_notify_vld (o_notify_vld),
    .o_notify     (o_notify)
  );

  // No table lookup while the reset walk is still clearing entries
  a_no_rd_before_ready: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> st_ready
  ) else $error("state table read issued before init done");

endmodule

/* rtl/level_list_exe.sv */
/*
 * Level-list command logic
 * ADD, DEL and CLR on a descending-key list, plus best-level
 * change detection on entry 0
 */

`timescale 1ns/1ps

module level_list_exe (
  input  book_pkg::cmd_t        i_cmd,
  input  book_pkg::key_t        i_key,
  input  book_pkg::vol_t        i_size,
  input  book_pkg::book_state_t i_cur,
  output book_pkg::book_state_t o_nxt,
  output logic                  o_best_chg,
  output book_pkg::key_t        o_best_key,
  output book_pkg::vol_t        o_best_vol
);
  import book_pkg::*;

  logic [ENTRIES_N-1:0] hit;
  logic [ENTRIES_N-1:0] above;
  logic [ENTRIES_N-1:0] ins_pos;
  logic [ENTRIES_N-1:0] shift_dn;
  logic [ENTRIES_N-1:0] tail;
  logic                 run;
  vol_t                 hit_vol;
  logic [VOL_W:0]       add_sum;
  vol_t                 acc_vol;
  logic                 del_empty;
  key_t                 cur_best_key;
  vol_t                 cur_best_vol;

  // Key match, better-key mask and hit-onward mask
  always_comb begin
    run     = 1'b0;
    hit_vol = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      hit[i]   = i_cur.vld[i] && (i_cur.key[i] == i_key);
      above[i] = i_cur.vld[i] && (i_cur.key[i] > i_key);
      run      = run | hit[i];
      tail[i]  = run;
      if (hit[i])
        hit_vol = i_cur.vol[i];
    end
  end

  // New key goes right after the last better key
  // No slot at all when every entry is better
  assign ins_pos  = ~above & {above[ENTRIES_N-2:0], 1'b1};
  assign shift_dn = ~above & ~ins_pos;

  // Saturating accumulate
  assign add_sum   = {1'b0, hit_vol} + {1'b0, i_size};
  assign acc_vol   = add_sum[VOL_W] ? '1 : add_sum[VOL_W-1:0];
  assign del_empty = (hit_vol <= i_size);

  always_comb begin
    o_nxt = i_cur;
    case (i_cmd)
      CMD_ADD: begin
        if (|hit) begin
          for (int i = 0; i < ENTRIES_N; i++)
            if (hit[i])
              o_nxt.vol[i] = acc_vol;
        end else begin
          // Shift worse levels down, last one falls off
          for (int i = ENTRIES_N - 1; i > 0; i--) begin
            if (shift_dn[i]) begin
              o_nxt.vld[i] = i_cur.vld[i-1];
              o_nxt.key[i] = i_cur.key[i-1];
              o_nxt.vol[i] = i_cur.vol[i-1];
            end
          end
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (ins_pos[i]) begin
              o_nxt.vld[i] = 1'b1;
              o_nxt.key[i] = i_key;
              o_nxt.vol[i] = i_size;
            end
          end
        end
      end
      CMD_DEL: begin
        if ((|hit) && del_empty) begin
          // Remove level, lower levels move up
          for (int i = 0; i < ENTRIES_N - 1; i++) begin
            if (tail[i]) begin
              o_nxt.vld[i] = i_cur.vld[i+1];
              o_nxt.key[i] = i_cur.key[i+1];
              o_nxt.vol[i] = i_cur.vol[i+1];
            end
          end
          o_nxt.vld[ENTRIES_N-1] = 1'b0;
          o_nxt.key[ENTRIES_N-1] = '0;
          o_nxt.vol[ENTRIES_N-1] = '0;
        end else begin
          for (int i = 0; i < ENTRIES_N; i++)
            if (hit[i])
              o_nxt.vol[i] = i_cur.vol[i] - i_size;
        end
      end
      CMD_CLR: o_nxt = '0;
      default: o_nxt = i_cur;
    endcase
  end

  // Best level as seen on the notify bus, zero when empty
  assign cur_best_key = i_cur.vld[0] ? i_cur.key[0] : '0;
  assign cur_best_vol = i_cur.vld[0] ? i_cur.vol[0] : '0;
  assign o_best_key   = o_nxt.vld[0] ? o_nxt.key[0] : '0;
  assign o_best_vol   = o_nxt.vld[0] ? o_nxt.vol[0] : '0;

  assign o_best_chg = (i_cur.vld[0] != o_nxt.vld[0])
                    | (cur_best_key != o_best_key)
                    | (cur_best_vol != o_best_vol);

  // Next list keeps valid entries packed from index 0
  always_comb begin
    if (!$isunknown(o_nxt.vld)) begin
      a_vld_contig: assert final ((o_nxt.vld & (o_nxt.vld + 1'b1)) == '0)
        else $error("level list valid bits not contiguous");
    end
  end

endmodule

/* rtl/state_table.sv */
/*
 * Per-product level-list memory
 * Registered read, one write port, cleared by a walk after reset
 */

`timescale 1ns/1ps

module state_table #(
  parameter int PRODUCTS_N = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_rd_en,
  input  book_pkg::id_t         i_rd_addr,
  input  logic                  i_wr_en,
  input  book_pkg::id_t         i_wr_addr,
  input  book_pkg::book_state_t i_wr_data,
  output book_pkg::book_state_t o_rd_data,
  output logic                  o_ready
);
  import book_pkg::*;

  book_state_t mem [PRODUCTS_N];
  id_t         init_cnt;
  logic        init_busy;

  // Init walk, one entry per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == id_t'(PRODUCTS_N - 1))
        init_busy <= 1'b0;
    end
  end

  // Walk owns the write port until done
  always_ff @(posedge clk) begin
    if (init_busy)
      mem[init_cnt] <= '0;
    else if (i_wr_en)
      mem[i_wr_addr] <= i_wr_data;
  end

  // Read returns pre-write contents on a same-address collision
  always_ff @(posedge clk) begin
    if (i_rd_en)
      o_rd_data <= mem[i_rd_addr];
  end

  assign o_ready = ~init_busy;

endmodule

/* rtl/upd_decode.sv */
/*
 * Update decode, pipeline stages 1 and 2
 * Issues the state-table read in S1, or captures the S4 writeback
 * instead when it targets the same product
 */

`timescale 1ns/1ps

module upd_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_upd_vld,
  input  book_pkg::upd_req_t    i_upd,
  input  logic                  i_wb_vld,
  input  book_pkg::id_t         i_wb_id,
  input  book_pkg::book_state_t i_wb_state,
  output logic                  o_rd_en,
  output book_pkg::id_t         o_rd_addr,
  output logic                  o_s2_vld,
  output book_pkg::upd_req_t    o_s2_req,
  output logic                  o_s2_wrbk_vld,
  output book_pkg::book_state_t o_s2_wrbk_state
);
  import book_pkg::*;

  logic     s1_vld;
  upd_req_t s1_req;
  logic     wrbk_hit;

  // S4 writes this product at the next edge, so a table read now
  // would return the old list
  assign wrbk_hit  = s1_vld & i_wb_vld & (i_wb_id == s1_req.id);

  // Read only when the writeback does not cover it
  assign o_rd_en   = s1_vld & ~wrbk_hit;
  assign o_rd_addr = s1_req.id;

  // Stage valids and capture flag
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld        <= 1'b0;
      o_s2_vld      <= 1'b0;
      o_s2_wrbk_vld <= 1'b0;
    end else begin
      s1_vld        <= i_upd_vld;
      o_s2_vld      <= s1_vld;
      o_s2_wrbk_vld <= wrbk_hit;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (i_upd_vld)
      s1_req <= i_upd;
    if (s1_vld)
      o_s2_req <= s1_req;
    if (wrbk_hit)
      o_s2_wrbk_state <= i_wb_state;
  end

  // A captured list never comes with a table read behind it
  a_capture_no_read: assert property (
    @(posedge clk) disable iff (rst)
    o_s2_wrbk_vld |-> $past(i_wb_vld && !o_rd_en)
  ) else $error("table read issued alongside writeback capture");

endmodule

/* rtl/upd_execute.sv */
/*
 * Update execute, end of stage 2 and stage 3
 * Picks the freshest list for the S2 request from the forwarding
 * sources, then runs the level-list command in S3
 */

`timescale 1ns/1ps

module upd_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_s2_vld,
  input  book_pkg::upd_req_t    i_s2_req,
  input  logic                  i_s2_wrbk_vld,
  input  book_pkg::book_state_t i_s2_wrbk_state,
  input  book_pkg::book_state_t i_rd_data,
  input  logic                  i_wb_vld,
  input  book_pkg::id_t         i_wb_id,
  input  book_pkg::book_state_t i_wb_state,
  output logic                  o_s3_vld,
  output book_pkg::id_t         o_s3_id,
  output book_pkg::book_state_t o_nxt_state,
  output logic                  o_notify_vld,
  output book_pkg::notify_t     o_notify
);
  import book_pkg::*;

  localparam int STATE_W = $bits(book_state_t);

  logic        s3_vld;
  upd_req_t    s3_req;
  book_state_t s3_state;

  // Forwarding hits: [2] S3 next, [1] S4 writeback, [0] S1 capture
  logic [2:0]  fwd_raw;
  logic [2:0]  fwd_sel;
  logic        fwd_any;
  book_state_t s2_state;

  key_t        best_key;
  vol_t        best_vol;

  // Distance 1, the update just ahead in S3
  assign fwd_raw[2] = i_s2_vld & s3_vld & (s3_req.id == i_s2_req.id);
  // Distance 2, the update in S4
  assign fwd_raw[1] = i_s2_vld & i_wb_vld & (i_wb_id == i_s2_req.id);
  // Distance 3, captured in place of the table read
  assign fwd_raw[0] = i_s2_vld & i_s2_wrbk_vld;

  // Most recent source wins
  assign fwd_sel[2] = fwd_raw[2];
  assign fwd_sel[1] = fwd_raw[1] & ~fwd_raw[2];
  assign fwd_sel[0] = fwd_raw[0] & ~fwd_raw[1] & ~fwd_raw[2];
  assign fwd_any    = |fwd_raw;

  // AND-OR select, table data last since it arrives latest
  assign s2_state =
      ({STATE_W{fwd_sel[2]}} & o_nxt_state)
    | ({STATE_W{fwd_sel[1]}} & i_wb_state)
    | ({STATE_W{fwd_sel[0]}} & i_s2_wrbk_state)
    | ({STATE_W{~fwd_any}}   & i_rd_data);

  always_ff @(posedge clk) begin
    if (rst)
      s3_vld <= 1'b0;
    else
      s3_vld <= i_s2_vld;
  end

  always_ff @(posedge clk) begin
    if (i_s2_vld) begin
      s3_req   <= i_s2_req;
      s3_state <= s2_state;
    end
  end

  level_list_exe i_level_list_exe (
    .i_cmd      (s3_req.cmd),
    .i_key      (s3_req.key),
    .i_size     (s3_req.size),
    .i_cur      (s3_state),
    .o_nxt      (o_nxt_state),
    .o_best_chg (o_notify_vld),
    .o_best_key (best_key),
    .o_best_vol (best_vol)
  );

  assign o_s3_vld     = s3_vld;
  assign o_s3_id      = s3_req.id;
  assign o_notify.id  = s3_req.id;
  assign o_notify.key = best_key;
  assign o_notify.vol = best_vol;

  // AND-OR mux needs at most one source
  a_fwd_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(fwd_sel)
  ) else $error("multiple state forwarding sources selected");

endmodule

/* rtl/upd_result.sv */
/*
 * Update result, pipeline stage 4
 * Holds the writeback to the state table and the notify output
 */

`timescale 1ns/1ps

module upd_result (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_s3_vld,
  input  book_pkg::id_t         i_s3_id,
  input  book_pkg::book_state_t i_nxt_state,
  input  logic                  i_notify_vld,
  input  book_pkg::notify_t     i_notify,
  output logic                  o_wb_vld,
  output book_pkg::id_t         o_wb_id,
  output book_pkg::book_state_t o_wb_state,
  output logic                  o_notify_vld,
  output book_pkg::notify_t     o_notify
);

  logic notify_en;

  // Notify only for a live S3 update that moved the best level
  assign notify_en = i_s3_vld & i_notify_vld;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_vld     <= 1'b0;
      o_notify_vld <= 1'b0;
    end else begin
      o_wb_vld     <= i_s3_vld;
      o_notify_vld <= notify_en;
    end
  end

  // Writeback payload, table write lands one edge later
  always_ff @(posedge clk) begin
    if (i_s3_vld) begin
      o_wb_id    <= i_s3_id;
      o_wb_state <= i_nxt_state;
    end
  end

  // Notify payload holds between pulses
  always_ff @(posedge clk) begin
    if (notify_en)
      o_notify <= i_notify;
  end

  // Every notify belongs to the product being written back
  a_notify_has_wb: assert property (
    @(posedge clk) disable iff (rst)
    o_notify_vld |-> (o_wb_vld && (o_notify.id == o_wb_id))
  ) else $error("notify without matching writeback");

endmodule

/* tests/book_model.svh */
/*
 * Reference level-list model for the book updater testbench
 * One sorted list per product plus the queue of expected notifies
 */

`ifndef BOOK_MODEL_SVH
`define BOOK_MODEL_SVH

// Entry 0 holds the best key, only the first m_cnt entries count
key_t    m_key [PRODUCTS_N][ENTRIES_N];
vol_t    m_vol [PRODUCTS_N][ENTRIES_N];
int      m_cnt [PRODUCTS_N];

// Expected notifies with the cycle they show up on the output
notify_t exp_q [$];
int      exp_due_q [$];

function automatic void model_apply(input upd_req_t r, input int due);
  int      p;
  int      n;
  int      hit;
  int      pos;
  vol_t    max_vol;
  logic    old_vld;
  key_t    old_key;
  vol_t    old_vol;
  notify_t nt;
  p       = int'(r.id);
  n       = m_cnt[p];
  max_vol = '1;
  old_vld = (n > 0);
  old_key = old_vld ? m_key[p][0] : '0;
  old_vol = old_vld ? m_vol[p][0] : '0;
  hit     = -1;
  for (int i = 0; i < n; i++)
    if (m_key[p][i] == r.key)
      hit = i;
  case (r.cmd)
    CMD_ADD: begin
      if (hit >= 0) begin
        // Saturate instead of wrapping
        if (m_vol[p][hit] > max_vol - r.size)
          m_vol[p][hit] = max_vol;
        else
          m_vol[p][hit] = m_vol[p][hit] + r.size;
      end else begin
        pos = 0;
        while (pos < n && m_key[p][pos] > r.key)
          pos++;
        // Worse than a full list means dropped
        if (pos < ENTRIES_N) begin
          for (int i = ENTRIES_N - 1; i > pos; i--) begin
            m_key[p][i] = m_key[p][i-1];
            m_vol[p][i] = m_vol[p][i-1];
          end
          m_key[p][pos] = r.key;
          m_vol[p][pos] = r.size;
          if (n < ENTRIES_N)
            m_cnt[p] = n + 1;
        end
      end
    end
    CMD_DEL: begin
      if (hit >= 0 && m_vol[p][hit] <= r.size) begin
        for (int i = hit; i < n - 1; i++) begin
          m_key[p][i] = m_key[p][i+1];
          m_vol[p][i] = m_vol[p][i+1];
        end
        m_cnt[p] = n - 1;
      end else if (hit >= 0) begin
        m_vol[p][hit] = m_vol[p][hit] - r.size;
      end
    end
    CMD_CLR: m_cnt[p] = 0;
    default: ;
  endcase
  nt.id  = r.id;
  nt.key = (m_cnt[p] > 0) ? m_key[p][0] : '0;
  nt.vol = (m_cnt[p] > 0) ? m_vol[p][0] : '0;
  if (((m_cnt[p] > 0) != old_vld) || nt.key != old_key || nt.vol != old_vol) begin
    exp_q.push_back(nt);
    exp_due_q.push_back(due);
  end
endfunction

`endif

/* tests/tb_book_update.sv */
/*
 * Testbench for the price-level book updater
 * LFSR-driven requests, notify stream checked cycle by cycle
 * against a reference list model
 */

`timescale 1ns/1ps

module tb_book_update;
  import book_pkg::*;

  localparam int          PRODUCTS_N  = 8;
  localparam int          DRAIN_LIMIT = 16;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic     clk;
  logic     rst;
  logic     upd_vld;
  upd_req_t upd;
  logic     notify_vld;
  notify_t  notify;

  int          cyc = 0;
  logic [31:0] lfsr = 32'h6f2c;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_tests = 0;
  int          chk_base = 0;
  int          err_base = 0;

  `include "book_model.svh"

  book_update_top #(
    .PRODUCTS_N (PRODUCTS_N)
  ) i_book_update_top (
    .clk          (clk),
    .rst          (rst),
    .i_upd_vld    (upd_vld),
    .i_upd        (upd),
    .o_notify_vld (notify_vld),
    .o_notify     (notify)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Rising edge count read at the falling edge
  always @(posedge clk)
    cyc <= cyc + 1;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic upd_req_t mk_req(input int id, input cmd_t cmd, input int key,
                                      input int size);
    upd_req_t r;
    r.id   = id_t'(id);
    r.cmd  = cmd;
    r.key  = key_t'(key);
    r.size = vol_t'(size);
    return r;
  endfunction

  // Few distinct keys so ADD and DEL often hit a level
  function automatic upd_req_t rand_req(input int id_bits);
    upd_req_t   r;
    logic [2:0] c;
    r.id   = id_t'(rand_bits(id_bits));
    c      = 3'(rand_bits(3));
    r.cmd  = (c < 3'd5) ? CMD_ADD : ((c < 3'd7) ? CMD_DEL : CMD_CLR);
    r.key  = key_t'(32'h100 + rand_bits(3) * 32'h10);
    // Small sizes half the time and full range for saturation
    r.size = rand_bits(1) ? vol_t'(rand_bits(16)) : vol_t'(rand_bits(5));
    return r;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_notify();
    logic    due_now;
    notify_t exp_n;
    due_now = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
    check_val("o_notify_vld", notify_vld, due_now);
    if (due_now) begin
      exp_n = exp_q.pop_front();
      void'(exp_due_q.pop_front());
      check_val("o_notify.id", notify.id, exp_n.id);
      check_val("o_notify.key", notify.key, exp_n.key);
      check_val("o_notify.vol", notify.vol, exp_n.vol);
    end
  endtask

  // Check outputs then drive inputs on the falling edge
  task automatic step(input logic vld, input upd_req_t req);
    @(negedge clk);
    check_notify();
    upd_vld = vld;
    upd     = req;
    // Notify due 4 cycles after the input cycle
    if (vld)
      model_apply(req, cyc + 4);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, '0);
  endtask

  // Request followed by enough idle cycles for its notify
  task automatic send(input int id, input cmd_t cmd, input int key, input int size);
    step(1'b1, mk_req(id, cmd, key, size));
    idle(6);
  endtask

  task automatic end_test(input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      idle(1);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%s: %0d expected notifies never arrived", name, exp_q.size());
      exp_q.delete();
      exp_due_q.delete();
    end
    idle(4);
    n_tests++;
    $display("test %0d %s: %0d checks, %0d errors", n_tests, name,
             n_checks - chk_base, n_errors - err_base);
    chk_base = n_checks;
    err_base = n_errors;
  endtask

  initial begin
    rst     = 1'b1;
    upd_vld = 1'b0;
    upd     = '0;
    for (int p = 0; p < PRODUCTS_N; p++)
      m_cnt[p] = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // State table init walk
    idle(PRODUCTS_N);

    // New best keys notify and a worse key stays silent
    send(2, CMD_ADD, 100, 10);
    send(2, CMD_ADD, 200, 5);
    send(2, CMD_ADD, 150, 8);
    send(2, CMD_ADD, 300, 1);
    send(2, CMD_ADD, 50, 2);
    end_test("build_up");

    send(5, CMD_ADD, 500, 60000);
    send(5, CMD_ADD, 500, 60000);
    send(5, CMD_ADD, 400, 7);
    send(5, CMD_DEL, 500, 65535);
    send(5, CMD_DEL, 999, 1);
    send(5, CMD_DEL, 400, 3);
    send(5, CMD_DEL, 400, 4);
    end_test("accumulate_delete");

    send(6, CMD_ADD, 10, 1);
    send(6, CMD_CLR, 0, 0);
    send(6, CMD_CLR, 0, 0);
    for (int k = 4; k >= 1; k--)
      send(6, CMD_ADD, k * 10, k);
    // A key worse than all and then one that pushes key 10 out
    send(6, CMD_ADD, 5, 9);
    send(6, CMD_ADD, 35, 7);
    send(6, CMD_DEL, 40, 4);
    send(6, CMD_DEL, 35, 7);
    send(6, CMD_DEL, 30, 3);
    send(6, CMD_DEL, 20, 2);
    send(6, CMD_DEL, 10, 1);
    end_test("clear_overflow");

    // Two ids every cycle hits every hazard distance
    repeat (80)
      step(1'b1, rand_req(1));
    end_test("hazards");

    repeat (400)
      step(rand_bits(2) != 0, rand_req(ID_W));
    end_test("random_mixed");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
